// ==== src/tetrisGeomPkg.sv ====
`default_nettype none

package tetrisGeomPkg;

    localparam int boardCols = 10;
    localparam int boardRows = 20;
    localparam int cellCount = boardCols * boardRows;

    typedef logic [3:0] colT;
    typedef logic [4:0] rowT;
    typedef logic [2:0] pieceT;
    typedef logic [1:0] rotT;
    typedef logic [cellCount-1:0] boardT;

    // Per cell: bit 8 is the inside flag, bits 7:0 the board bit index
    typedef logic [3:0][8:0] cellSetT;

    localparam colT spawnCol = 4'd5;
    localparam rowT spawnRow = 5'd1;

    // Two-bit signed offsets
    localparam logic [1:0] offM2 = 2'b10;
    localparam logic [1:0] offM1 = 2'b11;
    localparam logic [1:0] off0  = 2'b00;
    localparam logic [1:0] offP1 = 2'b01;

    // Four (row, col) offset pairs, cell 0 in the top bits
    function automatic logic [15:0] shapeOffsets(pieceT pieceType, rotT rot);
        logic [15:0] offs;
        case ({pieceType, rot})
            {3'd0, 2'd1}, {3'd0, 2'd3}: offs = {offM2, off0, offM1, off0, off0, off0, offP1, off0};
            {3'd1, 2'd0}, {3'd1, 2'd1},
            {3'd1, 2'd2}, {3'd1, 2'd3}: offs = {offM1, off0, offM1, offP1, off0, off0, off0, offP1};
            {3'd2, 2'd0}: offs = {off0, offM1, off0, off0, off0, offP1, offM1, off0};
            {3'd2, 2'd1}: offs = {offM1, off0, off0, off0, offP1, off0, off0, offP1};
            {3'd2, 2'd2}: offs = {off0, offM1, off0, off0, off0, offP1, offP1, off0};
            {3'd2, 2'd3}: offs = {offM1, off0, off0, off0, offP1, off0, off0, offM1};
            {3'd3, 2'd0}: offs = {off0, offM1, off0, off0, off0, offP1, offM1, offP1};
            {3'd3, 2'd1}: offs = {offM1, off0, off0, off0, offP1, off0, offP1, offP1};
            {3'd3, 2'd2}: offs = {off0, offM1, off0, off0, off0, offP1, offP1, offM1};
            {3'd3, 2'd3}: offs = {offM1, off0, off0, off0, offP1, off0, offM1, offM1};
            {3'd4, 2'd0}: offs = {off0, offM1, off0, off0, offM1, off0, offM1, offP1};
            {3'd4, 2'd1}: offs = {off0, off0, off0, offM1, offM1, offM1, offP1, off0};
            {3'd4, 2'd2}: offs = {off0, off0, off0, offP1, offM1, offM1, offM1, off0};
            {3'd4, 2'd3}: offs = {off0, off0, off0, offM1, offM1, off0, offP1, offM1};
            // Horizontal bar
            default:      offs = {off0, offM2, off0, offM1, off0, off0, off0, offP1};
        endcase
        return offs;
    endfunction

    function automatic cellSetT pieceCells(pieceT pieceType, rotT rot, rowT row, colT col);
        logic [15:0] offs;
        logic [1:0] dr;
        logic [1:0] dc;
        int rr;
        int cc;
        cellSetT cells;
        offs = shapeOffsets(pieceType, rot);
        for (int k = 0; k < 4; k++) begin
            dr = offs[15 - 4 * k -: 2];
            dc = offs[13 - 4 * k -: 2];
            rr = int'(row) + int'($signed(dr));
            cc = int'(col) + int'($signed(dc));
            if (rr >= 0 && rr < boardRows && cc >= 0 && cc < boardCols) begin
                cells[k] = {1'b1, 8'(rr * boardCols + cc)};
            end else begin
                cells[k] = 9'd0;
            end
        end
        return cells;
    endfunction

endpackage

`default_nettype wire

// ==== src/tetrisCtrlPkg.sv ====
`default_nettype none

package tetrisCtrlPkg;

    // Keyboard codes
    typedef enum logic [1:0] {
        CmdNone   = 2'b00,
        CmdLeft   = 2'b01,
        CmdRight  = 2'b10,
        CmdRotate = 2'b11
    } cmdT;

    typedef enum logic [2:0] {
        StPlay,
        StLock,
        StClear,
        StSpawn,
        StOver
    } ctrlStateT;

    // Score wraps at 128
    typedef logic [6:0] scoreT;

    localparam scoreT lockPoints = 7'd1;
    localparam scoreT rowPoints  = 7'd10;

endpackage

`default_nettype wire

// ==== src/commandSource.sv ====
`timescale 1ns/100ps
`default_nettype none

module commandSource #(
    parameter int dropPeriod = 64
) (
    input  wire                      clk,
    input  wire                      rstReg,
    input  wire tetrisCtrlPkg::cmdT  keyboardSignal,
    input  wire                      moveAck,
    input  wire                      dropAck,
    input  wire                      running,
    output tetrisCtrlPkg::cmdT       moveCmd,
    output logic                     dropReq
);

    localparam int cntWidth = $clog2(dropPeriod + 1);

    tetrisCtrlPkg::cmdT prevKey;
    logic [cntWidth-1:0] dropCount;
    logic keyEdge;
    logic dropTick;

    // Press is idle to non-idle only
    assign keyEdge = (prevKey == tetrisCtrlPkg::CmdNone) &&
                     (keyboardSignal != tetrisCtrlPkg::CmdNone);
    assign dropTick = running && (dropCount == cntWidth'(dropPeriod - 1));

    always_ff @(posedge clk) begin
        if (rstReg) begin
            prevKey <= tetrisCtrlPkg::CmdNone;
            moveCmd <= tetrisCtrlPkg::CmdNone;
        end else begin
            prevKey <= keyboardSignal;
            if (keyEdge && (moveCmd == tetrisCtrlPkg::CmdNone || moveAck)) begin
                moveCmd <= keyboardSignal;
            end else if (moveAck) begin
                moveCmd <= tetrisCtrlPkg::CmdNone;
            end
        end
    end

    // Gravity timer, a tick on a pending request merges into it
    always_ff @(posedge clk) begin
        if (rstReg) begin
            dropCount <= '0;
            dropReq <= 1'b0;
        end else begin
            if (running) begin
                dropCount <= dropTick ? '0 : dropCount + 1'b1;
            end
            if (dropTick) begin
                dropReq <= 1'b1;
            end else if (dropAck) begin
                dropReq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/pieceGenerator.sv ====
`timescale 1ns/100ps
`default_nettype none

module pieceGenerator #(
    parameter logic [15:0] lfsrSeed = 16'hACE1
) (
    input  wire                  clk,
    input  wire                  rstReg,
    input  wire                  takeNext,
    output tetrisGeomPkg::pieceT nextType
);

    logic [15:0] lfsr;
    logic feedback;

    // Taps 16, 14, 13, 11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (rstReg) begin
            lfsr <= lfsrSeed;
            nextType <= '0;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
            if (takeNext) begin
                nextType <= tetrisGeomPkg::pieceT'(lfsr % 16'd5);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/playfield.sv ====
`timescale 1ns/100ps
`default_nettype none

module playfield (
    input  wire                        clk,
    input  wire                        rstReg,
    input  wire tetrisGeomPkg::pieceT  probeType,
    input  wire tetrisGeomPkg::rotT    probeRot,
    input  wire tetrisGeomPkg::rowT    probeRow,
    input  wire tetrisGeomPkg::colT    probeCol,
    output logic                       probeBlocked,
    input  wire tetrisGeomPkg::pieceT  pieceType,
    input  wire tetrisGeomPkg::rotT    pieceRot,
    input  wire tetrisGeomPkg::rowT    pieceRow,
    input  wire tetrisGeomPkg::colT    pieceCol,
    input  wire                        pieceVisible,
    input  wire                        lockPiece,
    output logic                       clearBusy,
    output logic                       rowCleared,
    output tetrisGeomPkg::boardT       objects
);

    localparam int cols = tetrisGeomPkg::boardCols;
    localparam int rows = tetrisGeomPkg::boardRows;

    tetrisGeomPkg::boardT locked;
    tetrisGeomPkg::boardT pieceMask;
    tetrisGeomPkg::cellSetT probeSet;
    tetrisGeomPkg::cellSetT activeSet;
    tetrisGeomPkg::rowT scanRow;
    logic rowFull;

    // ############################################################
    // Collision probe and active piece mask
    // ############################################################

    always_comb begin
        probeSet = tetrisGeomPkg::pieceCells(probeType, probeRot, probeRow, probeCol);
        probeBlocked = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (!probeSet[k][8] || locked[probeSet[k][7:0]]) begin
                probeBlocked = 1'b1;
            end
        end
    end

    always_comb begin
        activeSet = tetrisGeomPkg::pieceCells(pieceType, pieceRot, pieceRow, pieceCol);
        pieceMask = '0;
        for (int k = 0; k < 4; k++) begin
            if (activeSet[k][8]) begin
                pieceMask[activeSet[k][7:0]] = 1'b1;
            end
        end
    end

    assign objects = locked | (pieceVisible ? pieceMask : '0);

    // ############################################################
    // Lock and bottom-up row clear
    // ############################################################

    assign rowFull = &locked[scanRow * cols +: cols];

    always_ff @(posedge clk) begin
        if (rstReg) begin
            locked <= '0;
            clearBusy <= 1'b0;
            rowCleared <= 1'b0;
        end else begin
            rowCleared <= 1'b0;
            if (lockPiece) begin
                locked <= locked | pieceMask;
                clearBusy <= 1'b1;
            end else if (clearBusy) begin
                if (rowFull) begin
                    // Shift everything above down, rescan the same row
                    for (int r = rows - 1; r > 0; r--) begin
                        if (r <= int'(scanRow)) begin
                            locked[r * cols +: cols] <= locked[(r - 1) * cols +: cols];
                        end
                    end
                    locked[cols-1:0] <= '0;
                    rowCleared <= 1'b1;
                end else if (scanRow == '0) begin
                    clearBusy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lockPiece) begin
            scanRow <= tetrisGeomPkg::rowT'(rows - 1);
        end else if (clearBusy && !rowFull && scanRow != '0) begin
            scanRow <= scanRow - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/pieceController.sv ====
`timescale 1ns/100ps
`default_nettype none

module pieceController (
    input  wire                        clk,
    input  wire                        rstReg,
    input  wire tetrisCtrlPkg::cmdT    moveCmd,
    input  wire                        dropReq,
    output logic                       moveAck,
    output logic                       dropAck,
    output logic                       running,
    output tetrisGeomPkg::pieceT       probeType,
    output tetrisGeomPkg::rotT         probeRot,
    output tetrisGeomPkg::rowT         probeRow,
    output tetrisGeomPkg::colT         probeCol,
    input  wire                        probeBlocked,
    output tetrisGeomPkg::pieceT       pieceType,
    output tetrisGeomPkg::rotT         pieceRot,
    output tetrisGeomPkg::rowT         pieceRow,
    output tetrisGeomPkg::colT         pieceCol,
    output logic                       pieceVisible,
    output logic                       lockPiece,
    input  wire                        clearBusy,
    input  wire                        rowCleared,
    input  wire tetrisGeomPkg::pieceT  nextType,
    output logic                       takeNext,
    output tetrisCtrlPkg::scoreT       score,
    output logic                       fail
);

    tetrisCtrlPkg::ctrlStateT state;
    logic [2:0] rowsCleared;
    logic movePending;
    logic inPlay;

    assign inPlay = (state == tetrisCtrlPkg::StPlay);
    assign movePending = (moveCmd != tetrisCtrlPkg::CmdNone);

    // Moves outside play are simply dropped
    assign moveAck = movePending;
    assign dropAck = inPlay && !movePending && dropReq;
    assign running = (state != tetrisCtrlPkg::StOver);
    assign lockPiece = (state == tetrisCtrlPkg::StLock);
    assign pieceVisible = inPlay || lockPiece;
    assign takeNext = (state == tetrisCtrlPkg::StSpawn) && !probeBlocked;

    // Candidate position
    always_comb begin
        probeType = pieceType;
        probeRot = pieceRot;
        probeRow = pieceRow;
        probeCol = pieceCol;
        if (inPlay) begin
            case (moveCmd)
                tetrisCtrlPkg::CmdLeft:   probeCol = pieceCol - 1'b1;
                tetrisCtrlPkg::CmdRight:  probeCol = pieceCol + 1'b1;
                tetrisCtrlPkg::CmdRotate: probeRot = pieceRot + 1'b1;
                default: begin
                    if (dropReq) begin
                        probeRow = pieceRow + 1'b1;
                    end
                end
            endcase
        end else if (state == tetrisCtrlPkg::StSpawn) begin
            probeType = nextType;
            probeRot = '0;
            probeRow = tetrisGeomPkg::spawnRow;
            probeCol = tetrisGeomPkg::spawnCol;
        end
    end

    always_ff @(posedge clk) begin
        if (rstReg) begin
            state <= tetrisCtrlPkg::StPlay;
            pieceType <= '0;
            pieceRot <= '0;
            pieceRow <= tetrisGeomPkg::spawnRow;
            pieceCol <= tetrisGeomPkg::spawnCol;
            rowsCleared <= '0;
            score <= '0;
            fail <= 1'b0;
        end else begin
            case (state)
                tetrisCtrlPkg::StPlay: begin
                    if (movePending) begin
                        if (!probeBlocked) begin
                            pieceRot <= probeRot;
                            pieceCol <= probeCol;
                        end
                    end else if (dropReq) begin
                        if (!probeBlocked) begin
                            pieceRow <= probeRow;
                        end else begin
                            state <= tetrisCtrlPkg::StLock;
                        end
                    end
                end
                tetrisCtrlPkg::StLock: begin
                    rowsCleared <= '0;
                    state <= tetrisCtrlPkg::StClear;
                end
                tetrisCtrlPkg::StClear: begin
                    if (rowCleared) begin
                        rowsCleared <= rowsCleared + 1'b1;
                    end
                    if (!clearBusy) begin
                        state <= tetrisCtrlPkg::StSpawn;
                    end
                end
                tetrisCtrlPkg::StSpawn: begin
                    score <= score + tetrisCtrlPkg::lockPoints +
                             tetrisCtrlPkg::scoreT'(tetrisCtrlPkg::rowPoints * rowsCleared);
                    if (probeBlocked) begin
                        fail <= 1'b1;
                        state <= tetrisCtrlPkg::StOver;
                    end else begin
                        pieceType <= probeType;
                        pieceRot <= probeRot;
                        pieceRow <= probeRow;
                        pieceCol <= probeCol;
                        state <= tetrisCtrlPkg::StPlay;
                    end
                end
                default: begin
                    // Game over holds everything
                    state <= tetrisCtrlPkg::StOver;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/tetrisGame.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetrisGame #(
    parameter int          dropPeriod = 64,
    parameter logic [15:0] lfsrSeed   = 16'hACE1
) (
    input  wire                      clk,
    input  wire                      rstReg,
    input  wire tetrisCtrlPkg::cmdT  keyboardSignal,
    output tetrisCtrlPkg::scoreT     score,
    output tetrisGeomPkg::pieceT     nextBlock,
    output tetrisGeomPkg::boardT     objects,
    output logic                     fail
);

    tetrisCtrlPkg::cmdT moveCmd;
    logic dropReq;
    logic moveAck;
    logic dropAck;
    logic running;
    tetrisGeomPkg::pieceT probeType;
    tetrisGeomPkg::rotT probeRot;
    tetrisGeomPkg::rowT probeRow;
    tetrisGeomPkg::colT probeCol;
    logic probeBlocked;
    tetrisGeomPkg::pieceT pieceType;
    tetrisGeomPkg::rotT pieceRot;
    tetrisGeomPkg::rowT pieceRow;
    tetrisGeomPkg::colT pieceCol;
    logic pieceVisible;
    logic lockPiece;
    logic clearBusy;
    logic rowCleared;
    logic takeNext;

    commandSource #(
        .dropPeriod(dropPeriod)
    ) commandSourceInst (
        .clk(clk),
        .rstReg(rstReg),
        .keyboardSignal(keyboardSignal),
        .moveAck(moveAck),
        .dropAck(dropAck),
        .running(running),
        .moveCmd(moveCmd),
        .dropReq(dropReq)
    );

    pieceGenerator #(
        .lfsrSeed(lfsrSeed)
    ) pieceGeneratorInst (
        .clk(clk),
        .rstReg(rstReg),
        .takeNext(takeNext),
        .nextType(nextBlock)
    );

    playfield playfieldInst (
        .clk(clk),
        .rstReg(rstReg),
        .probeType(probeType),
        .probeRot(probeRot),
        .probeRow(probeRow),
        .probeCol(probeCol),
        .probeBlocked(probeBlocked),
        .pieceType(pieceType),
        .pieceRot(pieceRot),
        .pieceRow(pieceRow),
        .pieceCol(pieceCol),
        .pieceVisible(pieceVisible),
        .lockPiece(lockPiece),
        .clearBusy(clearBusy),
        .rowCleared(rowCleared),
        .objects(objects)
    );

    pieceController pieceControllerInst (
        .clk(clk),
        .rstReg(rstReg),
        .moveCmd(moveCmd),
        .dropReq(dropReq),
        .moveAck(moveAck),
        .dropAck(dropAck),
        .running(running),
        .probeType(probeType),
        .probeRot(probeRot),
        .probeRow(probeRow),
        .probeCol(probeCol),
        .probeBlocked(probeBlocked),
        .pieceType(pieceType),
        .pieceRot(pieceRot),
        .pieceRow(pieceRow),
        .pieceCol(pieceCol),
        .pieceVisible(pieceVisible),
        .lockPiece(lockPiece),
        .clearBusy(clearBusy),
        .rowCleared(rowCleared),
        .nextType(nextBlock),
        .takeNext(takeNext),
        .score(score),
        .fail(fail)
    );

endmodule

`default_nettype wire

// ==== bench/tetrisTbTasks.svh ====
`ifndef tetrisTbTasksSvh
`define tetrisTbTasksSvh

localparam int tbCols = 10;
localparam int tbRows = 20;
localparam int tbSpawnRow = 1;
localparam int tbSpawnCol = 5;

// ############################################################
// Reference shapes and board helpers
// ############################################################

// Each byte is one cell as hex digits (row + 2, col + 2)
function automatic logic [31:0] shapeCode(input int pieceType, input int rot);
    logic [31:0] code;
    case (pieceType)
        0: code = (rot % 2 == 0) ? 32'h2021_2223 : 32'h0212_2232;
        1: code = 32'h1213_2223;
        2: code = (rot == 0) ? 32'h2122_2312 : (rot == 1) ? 32'h1222_3223 :
                  (rot == 2) ? 32'h2122_2332 : 32'h1222_3221;
        3: code = (rot == 0) ? 32'h2122_2313 : (rot == 1) ? 32'h1222_3233 :
                  (rot == 2) ? 32'h2122_2331 : 32'h1222_3211;
        default: code = (rot == 0) ? 32'h2122_1213 : (rot == 1) ? 32'h2221_1132 :
                        (rot == 2) ? 32'h2223_1112 : 32'h2221_1231;
    endcase
    return code;
endfunction

function automatic logic [199:0] shapeImage(input int pieceType, input int rot,
                                            input int row, input int col);
    logic [31:0] code;
    logic [199:0] image;
    int r;
    int c;
    code = shapeCode(pieceType, rot);
    image = '0;
    for (int k = 0; k < 4; k++) begin
        r = row + int'(code[31 - 8 * k -: 4]) - 2;
        c = col + int'(code[27 - 8 * k -: 4]) - 2;
        if (r >= 0 && r < tbRows && c >= 0 && c < tbCols) begin
            image[r * tbCols + c] = 1'b1;
        end
    end
    return image;
endfunction

function automatic int shapeTop(input int pieceType, input int rot);
    logic [31:0] code;
    int top;
    code = shapeCode(pieceType, rot);
    top = 2;
    for (int k = 0; k < 4; k++) begin
        if (int'(code[31 - 8 * k -: 4]) - 2 < top) begin
            top = int'(code[31 - 8 * k -: 4]) - 2;
        end
    end
    return top;
endfunction

function automatic int topRow(input logic [199:0] board);
    for (int r = 0; r < tbRows; r++) begin
        if (board[r * tbCols +: tbCols] != '0) begin
            return r;
        end
    end
    return tbRows;
endfunction

function automatic int leftmostCol(input logic [199:0] board);
    int col;
    col = tbCols;
    for (int i = 0; i < tbRows * tbCols; i++) begin
        if (board[i] && i % tbCols < col) begin
            col = i % tbCols;
        end
    end
    return col;
endfunction

function automatic int rightmostCol(input logic [199:0] board);
    int col;
    col = -1;
    for (int i = 0; i < tbRows * tbCols; i++) begin
        if (board[i] && i % tbCols > col) begin
            col = i % tbCols;
        end
    end
    return col;
endfunction

function automatic int countCells(input logic [199:0] board);
    int total;
    total = 0;
    for (int i = 0; i < tbRows * tbCols; i++) begin
        total += board[i];
    end
    return total;
endfunction

// Row follows the board, so gravity does not matter
function automatic logic [199:0] expectedImage(input int pieceType, input int rot,
                                               input int col, input logic [199:0] board);
    return shapeImage(pieceType, rot, topRow(board) - shapeTop(pieceType, rot), col);
endfunction

function automatic tetrisCtrlPkg::cmdT randomKey();
    case ($urandom % 3)
        0: return tetrisCtrlPkg::CmdLeft;
        1: return tetrisCtrlPkg::CmdRight;
        default: return tetrisCtrlPkg::CmdRotate;
    endcase
endfunction

// ############################################################
// Checking, waiting and driving
// ############################################################

task automatic endWithFailure();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
endtask

task automatic reportTimeout(input string what);
    $display("Timeout: %s", what);
    endWithFailure();
endtask

task automatic checkValue(input string testName, input logic [199:0] expected,
                          input logic [199:0] actual);
    if (expected !== actual) begin
        $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
        endWithFailure();
    end
endtask

task automatic applyReset();
    rstReg = 1'b1;
    keyboardSignal = tetrisCtrlPkg::CmdNone;
    repeat (5) @(negedge clk);
    rstReg = 1'b0;
endtask

task automatic waitForPieceRow(input int minRow);
    int waited;
    waited = 0;
    while (topRow(objects) < minRow && waited < 4 * dropPeriod) begin
        @(negedge clk);
        waited++;
    end
    if (topRow(objects) < minRow) begin
        reportTimeout("piece did not fall to the expected row");
    end
endtask

// Blocked moves match at once, then must stay put while held
task automatic pressKey(input string testName, input tetrisCtrlPkg::cmdT key,
                        input int holdCycles, input int expType, input int expRot,
                        input int expCol);
    int waited;
    @(negedge clk);
    keyboardSignal = key;
    waited = 0;
    while (objects !== expectedImage(expType, expRot, expCol, objects) && waited < 4) begin
        @(negedge clk);
        waited++;
    end
    checkValue(testName, expectedImage(expType, expRot, expCol, objects), objects);
    for (int i = 0; i < holdCycles; i++) begin
        @(negedge clk);
        checkValue(testName, expectedImage(expType, expRot, expCol, objects), objects);
    end
    keyboardSignal = tetrisCtrlPkg::CmdNone;
    @(negedge clk);
    checkValue(testName, expectedImage(expType, expRot, expCol, objects), objects);
endtask

// ############################################################
// Tests
// ############################################################

task automatic testReset();
    checkValue("testReset score", 0, score);
    checkValue("testReset fail", 0, fail);
    checkValue("testReset nextBlock", 0, nextBlock);
    checkValue("testReset objects", shapeImage(0, 0, tbSpawnRow, tbSpawnCol), objects);
endtask

task automatic testMoves();
    applyReset();
    // Held key moves only once
    pressKey("testMoves left", tetrisCtrlPkg::CmdLeft, 12, 0, 0, 4);
    pressKey("testMoves right", tetrisCtrlPkg::CmdRight, 3, 0, 0, 5);
    // Vertical bar needs two rows above its center
    waitForPieceRow(2);
    pressKey("testMoves rotate", tetrisCtrlPkg::CmdRotate, 3, 0, 1, 5);
    pressKey("testMoves rotate again", tetrisCtrlPkg::CmdRotate, 3, 0, 2, 5);
    pressKey("testMoves left rotated", tetrisCtrlPkg::CmdLeft, 3, 0, 2, 4);
endtask

task automatic testBorders();
    int col;
    applyReset();
    col = tbSpawnCol;
    for (int i = 0; i < 6; i++) begin
        if (col > 2) begin
            col--;
        end
        pressKey("testBorders left", tetrisCtrlPkg::CmdLeft, 3, 0, 0, col);
    end
    checkValue("testBorders left wall", 0, leftmostCol(objects));
    for (int i = 0; i < 9; i++) begin
        if (col < tbCols - 2) begin
            col++;
        end
        pressKey("testBorders right", tetrisCtrlPkg::CmdRight, 3, 0, 0, col);
    end
    checkValue("testBorders right wall", 9, rightmostCol(objects));
endtask

task automatic testScoring();
    int oldLocked;
    int newLocked;
    int removed;
    int idleCycles;
    int events;
    int cycle;
    tetrisCtrlPkg::scoreT oldScore;
    tetrisCtrlPkg::scoreT expScore;
    tetrisGeomPkg::pieceT oldNext;
    logic [199:0] image;
    applyReset();
    oldLocked = countCells(objects) - 4;
    oldScore = score;
    oldNext = nextBlock;
    events = 0;
    idleCycles = 0;
    cycle = 0;
    while (events < 12 && !fail) begin
        @(negedge clk);
        cycle++;
        if (cycle % 6 == 0) begin
            if (keyboardSignal == tetrisCtrlPkg::CmdNone) begin
                keyboardSignal = randomKey();
            end else begin
                keyboardSignal = tetrisCtrlPkg::CmdNone;
            end
        end
        if (score !== oldScore) begin
            newLocked = fail ? countCells(objects) : countCells(objects) - 4;
            removed = oldLocked + 4 - newLocked;
            checkValue("testScoring removed cells", 1, removed >= 0);
            checkValue("testScoring whole rows", 0, removed % 10);
            expScore = oldScore + 7'd1 + 7'(10 * (removed / 10));
            checkValue("testScoring score", expScore, score);
            if (!fail) begin
                image = shapeImage(oldNext, 0, tbSpawnRow, tbSpawnCol);
                checkValue("testScoring spawned piece", image, objects & image);
            end
            checkValue("testScoring nextBlock range", 1, nextBlock <= 4);
            oldLocked = newLocked;
            oldScore = score;
            oldNext = nextBlock;
            events++;
            idleCycles = 0;
        end else begin
            idleCycles++;
            if (idleCycles > 4000) begin
                reportTimeout("score did not change, no piece locked");
            end
        end
    end
    keyboardSignal = tetrisCtrlPkg::CmdNone;
endtask

task automatic testGameOver();
    int waited;
    tetrisGeomPkg::boardT frozenImage;
    tetrisCtrlPkg::scoreT frozenScore;
    applyReset();
    waited = 0;
    while (!fail && waited < 100000) begin
        @(negedge clk);
        waited++;
    end
    if (!fail) begin
        reportTimeout("fail did not rise with no keys pressed");
    end
    frozenImage = objects;
    frozenScore = score;
    // Keys keep coming after game over
    for (int i = 0; i < 400; i++) begin
        @(negedge clk);
        if (i % 5 == 0) begin
            keyboardSignal = (keyboardSignal == tetrisCtrlPkg::CmdNone) ?
                             randomKey() : tetrisCtrlPkg::CmdNone;
        end
        checkValue("testGameOver objects", frozenImage, objects);
        checkValue("testGameOver score", frozenScore, score);
        checkValue("testGameOver fail", 1, fail);
    end
    keyboardSignal = tetrisCtrlPkg::CmdNone;
endtask

`endif

// ==== bench/tetrisGameTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetrisGameTb;

    localparam int dropPeriod = 64;
    localparam logic [15:0] lfsrSeed = 16'hACE1;

    logic clk;
    logic rstReg;
    tetrisCtrlPkg::cmdT keyboardSignal;
    tetrisCtrlPkg::scoreT score;
    tetrisGeomPkg::pieceT nextBlock;
    tetrisGeomPkg::boardT objects;
    logic fail;
    int unsigned seedValue;

    tetrisGame #(
        .dropPeriod(dropPeriod),
        .lfsrSeed(lfsrSeed)
    ) uut (
        .clk(clk),
        .rstReg(rstReg),
        .keyboardSignal(keyboardSignal),
        .score(score),
        .nextBlock(nextBlock),
        .objects(objects),
        .fail(fail)
    );

    `include "tetrisTbTasks.svh"

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ############################################################
    // Test sequence
    // ############################################################

    initial begin
        rstReg = 1'b1;
        keyboardSignal = tetrisCtrlPkg::CmdNone;
        seedValue = $urandom(32'h032c_4d1b);
        applyReset();
        testReset();
        testMoves();
        testBorders();
        testScoring();
        testGameOver();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tetrisGame.f ====
+incdir+bench
src/tetrisGeomPkg.sv
src/tetrisCtrlPkg.sv
src/commandSource.sv
src/pieceGenerator.sv
src/playfield.sv
src/pieceController.sv
src/tetrisGame.sv
bench/tetrisGameTb.sv
